//--- Bender.yml
package:
  name: system

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/sys_map_pkg.sv
      - source/sys_bus_pkg.sv
      - source/credit_queue.sv
      - source/bus_arbiter.sv
      - source/bus_decoder.sv
      - source/system_memory.sv
      - source/io_regs.sv
      - source/system.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/system_checker.sv
      - sim/tb_system.sv

//--- include/system_cfg.svh
`ifndef SYSTEM_CFG_SVH
`define SYSTEM_CFG_SVH

// bus widths
`define ADDR_W 16
`define DATA_W 8

// memory sizes as address widths
`define PRG_AW 15
`define WK_AW 14

// six devices, four bytes each
`define JOY_BYTES 24

// entries per request queue, also the starting credits of each port
`define QUEUE_DEPTH 4

// 24 MHz clock
`define TICKS_PER_MS 24000

// address map
`define IO_STATUS 16'h8000
`define IO_TIMER 16'h80C0
`define IO_JOY 16'h8100
`define IO_PAUSE 16'h8530
`define IO_MENU 16'h8531
`define WK_BASE 16'hC000

`endif

//--- sim/system_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module system_checker import sys_bus_pkg::*; (
	input  wire logic       clk_24,
	input  wire logic       reset,
	input  wire logic       cpu_req_valid,
	input  wire cpu_req_t   cpu_req,
	input  wire logic       cpu_credit,
	input  wire logic       dn_valid,
	input  wire logic       dn_credit,
	input  wire cpu_rsp_t   cpu_rsp,
	input  wire logic [7:0] exp_rdata,
	input  wire logic       paused,
	input  wire logic       paused_check,
	input  wire logic       paused_exp,
	input  wire logic       final_check,
	output int              pending,
	output int              data_errors,
	output int              credit_errors,
	output int              misc_errors
);

	// address and expected byte of each read, oldest first
	logic [23:0] expected [$];
	logic [23:0] entry;
	int cpu_cred;
	int dn_cred;

	task automatic check_credits(input string port, input int count);
		if (count > `QUEUE_DEPTH)
		begin
			$display("%s port holds %0d credits, more than %0d", port, count, `QUEUE_DEPTH);
			credit_errors++;
		end
	endtask

	initial
	begin
		data_errors = 0;
		credit_errors = 0;
		misc_errors = 0;
		pending = 0;
	end

	// negedge sampling, everything here moves on the rising edge
	always @(negedge clk_24)
	begin
		if (reset)
		begin
			expected.delete();
			cpu_cred = `QUEUE_DEPTH;
			dn_cred = `QUEUE_DEPTH;
		end
		else
		begin
			if (cpu_rsp.valid && expected.size() == 0)
			begin
				$display("read response arrived with no read outstanding");
				misc_errors++;
			end
			else if (cpu_rsp.valid)
			begin
				entry = expected.pop_front();
				if (cpu_rsp.data !== entry[7:0])
				begin
					$display("FAILED cpu_rsp.data at 0x%04h: expected 0x%02h, got 0x%02h",
						entry[23:8], entry[7:0], cpu_rsp.data);
					data_errors++;
				end
			end
			if (cpu_req_valid && !cpu_req.write)
				expected.push_back({cpu_req.addr, exp_rdata});
			if (paused_check && paused !== paused_exp)
			begin
				$display("FAILED paused: expected 0x%01h, got 0x%01h", paused_exp, paused);
				data_errors++;
			end
			cpu_cred = cpu_cred - int'(cpu_req_valid) + int'(cpu_credit);
			dn_cred = dn_cred - int'(dn_valid) + int'(dn_credit);
			check_credits("cpu", cpu_cred);
			check_credits("download", dn_cred);
			if (final_check && (cpu_cred != `QUEUE_DEPTH || dn_cred != `QUEUE_DEPTH))
			begin
				$display("credits not all returned at the end: cpu %0d, download %0d",
					cpu_cred, dn_cred);
				credit_errors++;
			end
			if (final_check && expected.size() != 0)
			begin
				$display("%0d read responses never arrived", expected.size());
				misc_errors++;
			end
		end
		pending = expected.size();
	end

endmodule

`default_nettype wire

//--- sim/system_stim.txt
# columns: op addr data expect, all hex; data counts cycles for op 0, is a 32-bit word for op 4
# op 0 idle, 1 download write, 2 cpu write, 3 cpu read, 4 joystick word, 5 menu, 6 pause
1 0010 a5 00
1 0011 3c 00
1 7fff 96 00
0 0000 08 00
3 0010 00 a5
3 0011 00 3c
3 7fff 00 96
2 0010 ff 00
3 0010 00 a5
2 c000 11 00
2 ffff 22 00
3 c000 00 11
3 ffff 00 22
4 0000 04030201 00
4 0005 deadbeef 00
3 8101 00 02
3 8114 00 ef
3 8117 00 de
3 8118 00 00
3 9000 00 00
3 8000 00 08
0 0000 06 00
5 0000 01 00
3 8000 00 0a
0 0000 06 00
5 0000 00 00
3 8531 00 ff
2 8531 00 00
3 8531 00 00
2 80c0 00 00
3 80c0 00 00
3 80c1 00 00
2 8530 00 00
0 0000 06 00
6 0000 00 01
6 0000 01 01
6 0000 00 00
1 0020 5a 00
3 0011 00 3c
1 0021 6b 00
2 c001 33 00
1 0022 7c 00
3 c001 00 33
1 0023 8d 00
3 7fff 00 96
3 c000 00 11
0 0000 08 00
3 0020 00 5a
3 0023 00 8d

//--- sim/tb_system.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module tb_system import sys_bus_pkg::*; ();

	localparam logic [3:0] OP_IDLE = 4'h0;
	localparam logic [3:0] OP_DN_WR = 4'h1;
	localparam logic [3:0] OP_CPU_WR = 4'h2;
	localparam logic [3:0] OP_CPU_RD = 4'h3;
	localparam logic [3:0] OP_JOY = 4'h4;
	localparam logic [3:0] OP_MENU = 4'h5;
	localparam logic [3:0] OP_PAUSE = 4'h6;

	// both queues full and popped in turn, plus the response latency
	localparam int DRAIN_CYCLES = 4 * `QUEUE_DEPTH + 8;

	logic clk_24;
	logic reset;
	logic cpu_req_valid;
	cpu_req_t cpu_req;
	logic cpu_credit;
	logic dn_valid;
	dn_req_t dn_req;
	logic dn_credit;
	logic [8*`JOY_BYTES-1:0] joystick;
	logic menu;
	logic pause;
	cpu_rsp_t cpu_rsp;
	logic paused;

	logic [7:0] exp_rdata;
	logic paused_check;
	logic paused_exp;
	logic final_check;
	int pending;
	int data_errors;
	int credit_errors;
	int misc_errors;

	// one entry per stimulus line
	logic [3:0] op_q [$];
	logic [15:0] addr_q [$];
	logic [31:0] data_q [$];
	logic [7:0] exp_q [$];

	logic [31:0] lfsr_state;
	int cpu_cred;
	int dn_cred;
	int stim_lines;
	int drain;

	system DUT (
		.clk_24(clk_24), .reset(reset),
		.cpu_req_valid(cpu_req_valid), .cpu_req(cpu_req), .cpu_credit(cpu_credit),
		.dn_valid(dn_valid), .dn_req(dn_req), .dn_credit(dn_credit),
		.joystick(joystick), .menu(menu), .pause(pause),
		.cpu_rsp(cpu_rsp), .paused(paused)
	);

	system_checker scoreboard (
		.clk_24(clk_24), .reset(reset),
		.cpu_req_valid(cpu_req_valid), .cpu_req(cpu_req), .cpu_credit(cpu_credit),
		.dn_valid(dn_valid), .dn_credit(dn_credit), .cpu_rsp(cpu_rsp),
		.exp_rdata(exp_rdata), .paused(paused), .paused_check(paused_check),
		.paused_exp(paused_exp), .final_check(final_check), .pending(pending),
		.data_errors(data_errors), .credit_errors(credit_errors), .misc_errors(misc_errors)
	);

	initial
	begin
		clk_24 = 1'b0;
		forever #20 clk_24 = ~clk_24;
	end

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ 32'h8020_0003;
		return state >> 1;
	endfunction

	task automatic draw_bits(input int count, output int value);
		int b;
		value = 0;
		for (b = 0; b < count; b++)
		begin
			value = (value << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	function automatic logic uses_cpu(input logic [3:0] op);
		return op == OP_CPU_WR || op == OP_CPU_RD;
	endfunction

	function automatic logic uses_dn(input logic [3:0] op);
		return op == OP_DN_WR;
	endfunction

	function automatic logic pairable(input logic [3:0] a, input logic [3:0] b);
		return (uses_dn(a) && uses_cpu(b)) || (uses_cpu(a) && uses_dn(b));
	endfunction

	task automatic load_stimulus();
		int fd;
		int rc;
		logic [8*128-1:0] text;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_exp;
		fd = $fopen("sim/system_stim.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				text = '0;
				rc = $fgets(text, fd);
				// comment and blank lines do not scan as four fields
				if (rc != 0 && $sscanf(text, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4)
				begin
					op_q.push_back(f_op[3:0]);
					addr_q.push_back(f_addr[15:0]);
					data_q.push_back(f_data);
					exp_q.push_back(f_exp[7:0]);
				end
			end
			$fclose(fd);
		end
	endtask

	// one clock, with the credits held after that edge
	task automatic step_clock();
		@(posedge clk_24);
		cpu_cred = cpu_cred - int'(cpu_req_valid) + int'(cpu_credit);
		dn_cred = dn_cred - int'(dn_valid) + int'(dn_credit);
		cpu_req_valid <= 1'b0;
		dn_valid <= 1'b0;
		paused_check <= 1'b0;
	endtask

	task automatic wait_credits(input logic need_cpu, input logic need_dn);
		step_clock();
		while ((need_cpu && cpu_cred == 0) || (need_dn && dn_cred == 0))
			step_clock();
	endtask

	task automatic drive_line(input int k);
		case (op_q[k])
			OP_DN_WR:
			begin
				dn_valid <= 1'b1;
				dn_req.addr <= addr_q[k][`PRG_AW-1:0];
				dn_req.data <= data_q[k][7:0];
			end
			OP_CPU_WR, OP_CPU_RD:
			begin
				cpu_req_valid <= 1'b1;
				cpu_req.addr <= addr_q[k];
				cpu_req.wdata <= data_q[k][7:0];
				cpu_req.write <= op_q[k] == OP_CPU_WR;
				exp_rdata <= exp_q[k];
			end
			OP_JOY: joystick[int'(addr_q[k]) * 32 +: 32] <= data_q[k];
			OP_MENU: menu <= data_q[k][0];
			OP_PAUSE:
			begin
				pause <= data_q[k][0];
				paused_exp <= exp_q[k][0];
				paused_check <= 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic run_stimulus();
		int k;
		int gap;
		int pair;
		logic need_cpu;
		logic need_dn;
		k = 0;
		while (k < op_q.size())
		begin
			draw_bits(2, gap);
			repeat (gap)
				step_clock();
			pair = 0;
			if (k + 1 < op_q.size() && pairable(op_q[k], op_q[k + 1]))
				draw_bits(1, pair);
			if (op_q[k] == OP_IDLE)
				repeat (data_q[k])
					step_clock();
			else
			begin
				need_cpu = uses_cpu(op_q[k]) || (pair != 0 && uses_cpu(op_q[k + 1]));
				need_dn = uses_dn(op_q[k]) || (pair != 0 && uses_dn(op_q[k + 1]));
				wait_credits(need_cpu, need_dn);
				drive_line(k);
				if (pair != 0)
					drive_line(k + 1);
			end
			k = k + 1 + pair;
		end
	endtask

	task automatic print_counts();
		$display("errors: read data %0d, credit %0d, other %0d",
			data_errors, credit_errors, misc_errors);
	endtask

	initial
	begin
		reset = 1'b1;
		cpu_req_valid = 1'b0;
		cpu_req = '0;
		dn_valid = 1'b0;
		dn_req = '0;
		joystick = '0;
		menu = 1'b0;
		pause = 1'b0;
		exp_rdata = '0;
		paused_check = 1'b0;
		paused_exp = 1'b0;
		final_check = 1'b0;
		lfsr_state = 32'hf3f4_cdd7;
		cpu_cred = `QUEUE_DEPTH;
		dn_cred = `QUEUE_DEPTH;
		stim_lines = 0;
		drain = 0;
		load_stimulus();
		if (op_q.size() == 0)
		begin
			$display("stimulus file sim/system_stim.txt is missing or holds no operations");
			$display("TEST RESULT: FAIL");
		end
		else
		begin
			stim_lines = op_q.size();
			repeat (5) @(posedge clk_24);
			reset <= 1'b0;
			run_stimulus();
			// let the queues empty and the last responses come back
			step_clock();
			while ((cpu_cred != `QUEUE_DEPTH || dn_cred != `QUEUE_DEPTH || pending != 0)
				&& drain < DRAIN_CYCLES)
			begin
				step_clock();
				drain++;
			end
			final_check <= 1'b1;
			step_clock();
			final_check <= 1'b0;
			step_clock();
			print_counts();
			if (data_errors + credit_errors + misc_errors == 0)
				$display("TEST RESULT: PASS");
			else
				$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial
	begin
		wait (stim_lines > 0);
		repeat (20 * stim_lines + 200) @(posedge clk_24);
		$display("timeout: run did not finish within %0d cycles", 20 * stim_lines + 200);
		print_counts();
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module bus_arbiter import sys_bus_pkg::*; (
	input  wire logic     clk_24,
	input  wire logic     reset,
	input  wire cpu_req_t cpu_head,
	input  wire logic     cpu_ready,
	input  wire dn_req_t  dn_head,
	input  wire logic     dn_ready,
	output logic          cpu_pop,
	output logic          dn_pop,
	output bus_txn_t      txn
);

	bus_src_t last_winner;

	// download wins when alone, or when the cpu had the last grant
	assign dn_pop = dn_ready && (!cpu_ready || last_winner == SRC_CPU);
	assign cpu_pop = cpu_ready && !dn_pop;

	always_comb
	begin
		if (dn_pop)
		begin
			txn.en = 1'b1;
			txn.src = SRC_DN;
			txn.addr = {{(`ADDR_W - `PRG_AW){1'b0}}, dn_head.addr};
			txn.wdata = dn_head.data;
			txn.write = 1'b1;
		end
		else
		begin
			txn.en = cpu_pop;
			txn.src = SRC_CPU;
			txn.addr = cpu_head.addr;
			txn.wdata = cpu_head.wdata;
			txn.write = cpu_head.write;
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (reset)
			last_winner <= SRC_DN;
		else if (cpu_pop || dn_pop)
			last_winner <= dn_pop ? SRC_DN : SRC_CPU;
	end

	// a queue left waiting is served on the very next cycle
	assert property (@(posedge clk_24) disable iff (reset) cpu_pop && dn_ready |=> dn_pop)
		else $error("bus_arbiter: download queue passed over twice");

	assert property (@(posedge clk_24) disable iff (reset) dn_pop && cpu_ready |=> cpu_pop)
		else $error("bus_arbiter: cpu queue passed over twice");

endmodule

`default_nettype wire

//--- source/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module bus_decoder import sys_bus_pkg::*, sys_map_pkg::*; (
	input  wire logic     clk_24,
	input  wire logic     reset,
	input  wire bus_txn_t txn,
	output mem_cmd_t      mem_cmd,
	output io_cmd_t       io_cmd,
	input  wire logic [7:0] mem_rdata,
	input  wire logic [7:0] io_rdata,
	output cpu_rsp_t      cpu_rsp
);

	region_t region;
	io_reg_t io_sel;
	logic prg_lock;
	logic rd_due;
	region_t rd_region;
	logic [`DATA_W-1:0] rd_data;

	always_comb
	begin
		io_sel = IO_R_NONE;
		if (txn.addr == `IO_STATUS)
			io_sel = IO_R_STATUS;
		else if (txn.addr[`ADDR_W-1:1] == `IO_TIMER >> 1)
			io_sel = IO_R_TIMER;
		else if (txn.addr >= `IO_JOY && txn.addr < `IO_JOY + `JOY_BYTES)
			io_sel = IO_R_JOY;
		else if (txn.addr == `IO_PAUSE)
			io_sel = IO_R_PAUSE;
		else if (txn.addr == `IO_MENU)
			io_sel = IO_R_MENU;

		if (!txn.addr[`ADDR_W-1])
			region = REGION_PRG;
		else if (txn.addr >= `WK_BASE)
			region = REGION_WK;
		else if (io_sel != IO_R_NONE)
			region = REGION_IO;
		else
			region = REGION_NONE;
	end

	// program memory is read-only from the cpu side
	assign prg_lock = txn.src == SRC_CPU && txn.write && region == REGION_PRG;

	assign mem_cmd.en = txn.en && !prg_lock && (region == REGION_PRG || region == REGION_WK);
	assign mem_cmd.write = txn.write;
	assign mem_cmd.wk_sel = region == REGION_WK;
	assign mem_cmd.addr = txn.addr;
	assign mem_cmd.data = txn.wdata;

	assign io_cmd.en = txn.en && region == REGION_IO;
	assign io_cmd.write = txn.write;
	assign io_cmd.io_reg = io_sel;
	assign io_cmd.offset = txn.addr[$clog2(`JOY_BYTES)-1:0];
	assign io_cmd.data = txn.wdata;

	// targets answer one cycle after the command, unmapped reads give zero
	always_comb
	begin
		case (rd_region)
			REGION_PRG, REGION_WK: rd_data = mem_rdata;
			REGION_IO: rd_data = io_rdata;
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_24)
	begin
		rd_region <= region;
		cpu_rsp.data <= rd_data;
		if (reset)
		begin
			rd_due <= 1'b0;
			cpu_rsp.valid <= 1'b0;
		end
		else
		begin
			rd_due <= txn.en && !txn.write && txn.src == SRC_CPU;
			cpu_rsp.valid <= rd_due;
		end
	end

endmodule

`default_nettype wire

//--- source/credit_queue.sv
`timescale 1ns/1ps
`default_nettype none

module credit_queue #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input  wire logic     clk_24,
	input  wire logic     reset,
	input  wire logic     push_valid,
	input  wire payload_t push_data,
	input  wire logic     pop,
	output payload_t      head,
	output logic          not_empty,
	output logic          credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t store [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;

	assign full = count == CNT_W'(DEPTH);
	assign not_empty = count != '0;
	assign head = store[rd_ptr];
	// every entry that leaves hands one credit back to the port
	assign credit = pop;

	always_ff @(posedge clk_24)
	begin
		if (push_valid)
			store[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({push_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the requester must never spend a credit it does not hold
	assert property (@(posedge clk_24) disable iff (reset) push_valid |-> !full || pop)
		else $error("credit_queue: push while full");

	// the arbiter only pops a queue that reported an entry
	assert property (@(posedge clk_24) disable iff (reset) pop |-> not_empty)
		else $error("credit_queue: pop while empty");

endmodule

`default_nettype wire

//--- source/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module io_regs import sys_bus_pkg::*, sys_map_pkg::*; (
	input  wire logic     clk_24,
	input  wire logic     reset,
	input  wire io_cmd_t  io_cmd,
	input  wire logic [8*`JOY_BYTES-1:0] joystick,
	input  wire logic     menu,
	input  wire logic     pause,
	output logic [7:0]    io_rdata,
	output logic          paused
);

	localparam int PRESC_W = $clog2(`TICKS_PER_MS);

	logic [PRESC_W-1:0] prescale;
	logic [15:0] ms_timer;
	logic menu_trigger;
	logic pause_trigger;
	logic timer_clr;
	logic [`DATA_W-1:0] status;

	assign timer_clr = io_cmd.en && io_cmd.write && io_cmd.io_reg == IO_R_TIMER;

	// video and debug bits are gone, only menu and the fixed field remain
	assign status = {4'b0000, 2'b10, menu, 1'b0};

	assign paused = pause || pause_trigger;

	// millisecond counter, any timer write restarts it
	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clr)
		begin
			prescale <= '0;
			ms_timer <= '0;
		end
		else if (prescale == PRESC_W'(`TICKS_PER_MS - 1))
		begin
			prescale <= '0;
			ms_timer <= ms_timer + 1'b1;
		end
		else
			prescale <= prescale + 1'b1;
	end

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			menu_trigger <= 1'b0;
			pause_trigger <= 1'b0;
		end
		else
		begin
			if (menu)
				menu_trigger <= 1'b1;
			// the cpu acknowledges the menu request by writing the trigger
			if (io_cmd.en && io_cmd.write && io_cmd.io_reg == IO_R_MENU)
				menu_trigger <= 1'b0;
			if (io_cmd.en && io_cmd.write && io_cmd.io_reg == IO_R_PAUSE)
				pause_trigger <= 1'b1;
			// external pause takes over and releases the software pause
			if (pause)
				pause_trigger <= 1'b0;
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (io_cmd.en)
		begin
			case (io_cmd.io_reg)
				IO_R_STATUS: io_rdata <= status;
				IO_R_TIMER: io_rdata <= ms_timer[{io_cmd.offset[0], 3'd0} +: 8];
				IO_R_JOY: io_rdata <= joystick[{io_cmd.offset, 3'd0} +: 8];
				IO_R_MENU: io_rdata <= {8{menu_trigger}};
				default: io_rdata <= 8'h00;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/sys_bus_pkg.sv
`default_nettype none

`include "system_cfg.svh"

package sys_bus_pkg;

	import sys_map_pkg::*;

	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
		logic               write;
	} cpu_req_t;

	// download port only ever writes program memory
	typedef struct packed {
		logic [`PRG_AW-1:0] addr;
		logic [`DATA_W-1:0] data;
	} dn_req_t;

	typedef enum logic {
		SRC_CPU,
		SRC_DN
	} bus_src_t;

	typedef struct packed {
		logic               en;
		bus_src_t           src;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
		logic               write;
	} bus_txn_t;

	typedef struct packed {
		logic               en;
		logic               write;
		logic               wk_sel;
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] data;
	} mem_cmd_t;

	typedef struct packed {
		logic                           en;
		logic                           write;
		io_reg_t                        io_reg;
		logic [$clog2(`JOY_BYTES)-1:0] offset;
		logic [`DATA_W-1:0]             data;
	} io_cmd_t;

	typedef struct packed {
		logic               valid;
		logic [`DATA_W-1:0] data;
	} cpu_rsp_t;

endpackage

`default_nettype wire

//--- source/sys_map_pkg.sv
`default_nettype none

package sys_map_pkg;

	// which target a bus address lands on
	typedef enum logic [1:0] {
		REGION_PRG,
		REGION_WK,
		REGION_IO,
		REGION_NONE
	} region_t;

	// memory-mapped registers in the I/O page
	typedef enum logic [2:0] {
		IO_R_STATUS,
		IO_R_TIMER,
		IO_R_JOY,
		IO_R_PAUSE,
		IO_R_MENU,
		IO_R_NONE
	} io_reg_t;

endpackage

`default_nettype wire

//--- source/system.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module system import sys_bus_pkg::*; (
	input  wire logic     clk_24,
	input  wire logic     reset,
	input  wire logic     cpu_req_valid,
	input  wire cpu_req_t cpu_req,
	output logic          cpu_credit,
	input  wire logic     dn_valid,
	input  wire dn_req_t  dn_req,
	output logic          dn_credit,
	input  wire logic [8*`JOY_BYTES-1:0] joystick,
	input  wire logic     menu,
	input  wire logic     pause,
	output cpu_rsp_t      cpu_rsp,
	output logic          paused
);

	cpu_req_t cpu_head;
	dn_req_t dn_head;
	logic cpu_ready;
	logic dn_ready;
	logic cpu_pop;
	logic dn_pop;
	bus_txn_t txn;
	mem_cmd_t mem_cmd;
	io_cmd_t io_cmd;
	logic [7:0] mem_rdata;
	logic [7:0] io_rdata;

	credit_queue #(.payload_t(cpu_req_t), .DEPTH(`QUEUE_DEPTH)) cpu_queue (
		.clk_24(clk_24), .reset(reset),
		.push_valid(cpu_req_valid), .push_data(cpu_req),
		.pop(cpu_pop), .head(cpu_head), .not_empty(cpu_ready), .credit(cpu_credit)
	);

	credit_queue #(.payload_t(dn_req_t), .DEPTH(`QUEUE_DEPTH)) dn_queue (
		.clk_24(clk_24), .reset(reset),
		.push_valid(dn_valid), .push_data(dn_req),
		.pop(dn_pop), .head(dn_head), .not_empty(dn_ready), .credit(dn_credit)
	);

	bus_arbiter arbiter (
		.clk_24(clk_24), .reset(reset),
		.cpu_head(cpu_head), .cpu_ready(cpu_ready),
		.dn_head(dn_head), .dn_ready(dn_ready),
		.cpu_pop(cpu_pop), .dn_pop(dn_pop), .txn(txn)
	);

	bus_decoder decoder (
		.clk_24(clk_24), .reset(reset), .txn(txn),
		.mem_cmd(mem_cmd), .io_cmd(io_cmd),
		.mem_rdata(mem_rdata), .io_rdata(io_rdata), .cpu_rsp(cpu_rsp)
	);

	system_memory memory (.clk_24(clk_24), .mem_cmd(mem_cmd), .mem_rdata(mem_rdata));

	io_regs io (
		.clk_24(clk_24), .reset(reset), .io_cmd(io_cmd),
		.joystick(joystick), .menu(menu), .pause(pause),
		.io_rdata(io_rdata), .paused(paused)
	);

endmodule

`default_nettype wire

//--- source/system_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "system_cfg.svh"

module system_memory import sys_bus_pkg::*; (
	input  wire logic     clk_24,
	input  wire mem_cmd_t mem_cmd,
	output logic [7:0]    mem_rdata
);

	// 0x0000-0x7FFF, loaded through the download port
	logic [`DATA_W-1:0] prg_mem [2**`PRG_AW];
	// 0xC000-0xFFFF
	logic [`DATA_W-1:0] wk_mem [2**`WK_AW];

	logic [`PRG_AW-1:0] prg_addr;
	logic [`WK_AW-1:0] wk_addr;

	assign prg_addr = mem_cmd.addr[`PRG_AW-1:0];
	assign wk_addr = mem_cmd.addr[`WK_AW-1:0];

	always_ff @(posedge clk_24)
	begin
		if (mem_cmd.en && mem_cmd.write && !mem_cmd.wk_sel)
			prg_mem[prg_addr] <= mem_cmd.data;
		if (mem_cmd.en && mem_cmd.write && mem_cmd.wk_sel)
			wk_mem[wk_addr] <= mem_cmd.data;
		if (mem_cmd.en)
			mem_rdata <= mem_cmd.wk_sel ? wk_mem[wk_addr] : prg_mem[prg_addr];
	end

endmodule

`default_nettype wire

//--- system.f
+incdir+include
source/sys_map_pkg.sv
source/sys_bus_pkg.sv
source/credit_queue.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/system_memory.sv
source/io_regs.sv
source/system.sv
sim/system_checker.sv
sim/tb_system.sv
